//--- rob_top.f
logic/rob_cfg_pkg.sv
logic/rob_types_pkg.sv
logic/rob_bank.sv
logic/rob_retire_ctrl.sv
logic/preg_ready_table.sv
logic/rob_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rob_top.sv

//--- Bender.yml
package:
  name: rob_top

sources:
  # packages before the modules that use them
  - logic/rob_cfg_pkg.sv
  - logic/rob_types_pkg.sv
  - logic/rob_bank.sv
  - logic/rob_retire_ctrl.sv
  - logic/preg_ready_table.sv
  - logic/rob_top.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_rob_top.sv

//--- testbench/tb_rob_top.sv
`timescale 1ns/10ps

module tb_rob_top;

  localparam int DW        = rob_cfg_pkg::DISPATCH_WIDTH;
  localparam int ROB_ROWS  = rob_cfg_pkg::ROB_ROWS;
  localparam int NUM_PREGS = rob_cfg_pkg::NUM_PREGS;
  localparam int ROW_W     = rob_cfg_pkg::ROB_ADDR_WIDTH;
  localparam int PREG_W    = rob_cfg_pkg::PHYS_REGS_ADDR_WIDTH;
  localparam int BANK_W    = rob_cfg_pkg::DISPATCH_ADDR_WIDTH;

  localparam int RANDOM_CYCLES  = 300;
  // reset, random traffic, fill test and three drains
  localparam int PLANNED_CYCLES = 3 + RANDOM_CYCLES + 2 * ROB_ROWS + 3 * 4 * ROB_ROWS + 12;
  localparam int CYCLE_LIMIT    = 4 * PLANNED_CYCLES;

  logic                          clk;
  logic                          rst_n;
  rob_types_pkg::dispatch_lane_t dispatch [DW];
  logic [BANK_W-1:0]             dispatch_bank_addr [DW];
  logic [ROW_W-1:0]              dispatch_rob_addr [DW];
  logic                          dispatch_full;
  rob_types_pkg::wb_lane_t       writeback [DW];
  rob_types_pkg::commit_lane_t   commit [DW];
  logic [PREG_W-1:0]             op_fetch_phys_rs1 [DW];
  logic [PREG_W-1:0]             op_fetch_phys_rs2 [DW];
  logic                          op_fetch_rs1_valid [DW];
  logic                          op_fetch_rs2_valid [DW];

  // model state, rows kept in program order
  int                            row_q [$];
  bit                            m_valid [ROB_ROWS][DW];
  bit                            m_done [ROB_ROWS][DW];
  rob_types_pkg::rob_payload_t   m_payload [ROB_ROWS][DW];
  bit                            exp_ready [NUM_PREGS];
  bit                            busy [NUM_PREGS];
  bit                            exp_full;
  logic [PREG_W-1:0]             last_disp_rd;
  logic [PREG_W-1:0]             last_wb_rd;
  int unsigned                   groups_accepted;
  int unsigned                   rows_committed;
  int unsigned                   error_count;
  int unsigned                   cycle_count;

  tb_clock_gen clock_gen_inst (.clk, .rst_n);

  rob_top #(
    .DISPATCH_WIDTH (DW),
    .ROB_ROWS       (ROB_ROWS),
    .NUM_PREGS      (NUM_PREGS)
  ) rob_top_inst (
    .clk, .rst_n, .dispatch, .dispatch_bank_addr, .dispatch_rob_addr, .dispatch_full,
    .writeback, .commit, .op_fetch_phys_rs1, .op_fetch_phys_rs2,
    .op_fetch_rs1_valid, .op_fetch_rs2_valid
  );

  // oldest row leaves once lane 0 is done and any other live lane too
  function automatic bit row_retires();
    bit ok;
    if (row_q.size() == 0)
      return 1'b0;
    ok = m_valid[row_q[0]][0] && m_done[row_q[0]][0];
    for (int i = 1; i < DW; i++) begin
      ok = ok && (!m_valid[row_q[0]][i] || m_done[row_q[0]][i]);
    end
    return ok;
  endfunction

  function automatic rob_types_pkg::commit_lane_t expected_commit(int lane);
    rob_types_pkg::commit_lane_t c;
    c = '0;
    if (row_retires() && m_valid[row_q[0]][lane]) begin
      c.en      = 1'b1;
      c.payload = m_payload[row_q[0]][lane];
    end
    return c;
  endfunction

  function automatic logic [PREG_W-1:0] pick_free_preg(int avoid);
    int start;
    int p;
    start = $urandom_range(NUM_PREGS - 1);
    for (int k = 0; k < NUM_PREGS; k++) begin
      p = (start + k) % NUM_PREGS;
      if (!busy[p] && p != avoid)
        return PREG_W'(p);
    end
    return '0;
  endfunction

  task automatic report_mismatch(string name, logic [127:0] exp_val, logic [127:0] act_val);
    error_count++;
    $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
  endtask

  // what the rising edge just did, from the inputs it sampled
  task automatic apply_edge();
    int row;
    if (row_retires()) begin
      row = row_q.pop_front();
      for (int i = 0; i < DW; i++) begin
        if (m_valid[row][i])
          busy[m_payload[row][i].phys_rd] = 1'b0;
        m_valid[row][i] = 1'b0;
        m_done[row][i]  = 1'b0;
      end
      rows_committed++;
    end
    for (int i = 0; i < DW; i++) begin
      if (writeback[i].en) begin
        m_done[writeback[i].rob_addr][writeback[i].bank_addr] = 1'b1;
        exp_ready[writeback[i].phys_rd] = 1'b1;
        last_wb_rd = writeback[i].phys_rd;
      end
    end
    if (dispatch[0].en && !exp_full) begin
      row = groups_accepted % ROB_ROWS;
      for (int i = 0; i < DW; i++) begin
        if (dispatch[i].en) begin
          m_valid[row][i]   = 1'b1;
          m_done[row][i]    = 1'b0;
          m_payload[row][i] = dispatch[i].payload;
          busy[dispatch[i].payload.phys_rd]      = 1'b1;
          exp_ready[dispatch[i].payload.phys_rd] = 1'b0;
        end
      end
      last_disp_rd = dispatch[0].payload.phys_rd;
      row_q.push_back(row);
      groups_accepted++;
    end
    exp_full = (row_q.size() == ROB_ROWS);
  endtask

  task automatic clear_inputs();
    for (int i = 0; i < DW; i++) begin
      dispatch[i]  <= '0;
      writeback[i] <= '0;
    end
  endtask

  task automatic drive_group(int lanes);
    rob_types_pkg::rob_payload_t pl;
    int taken;
    taken = -1;
    for (int i = 0; i < lanes; i++) begin
      pl.phys_rd = pick_free_preg(taken);
      pl.arch_rd = rob_cfg_pkg::ARCH_REG_WIDTH'($urandom);
      pl.pc      = $urandom & 32'hffff_fffc;
      pl.instr   = $urandom;
      taken      = pl.phys_rd;
      dispatch[i].en      <= 1'b1;
      dispatch[i].payload <= pl;
    end
  endtask

  // order 0 random, 1 youngest first, 2 oldest first
  task automatic drive_writebacks(int max_wb, int order);
    int pend_row [$];
    int pend_lane [$];
    int n;
    int k;
    foreach (row_q[r]) begin
      for (int i = 0; i < DW; i++) begin
        if (m_valid[row_q[r]][i] && !m_done[row_q[r]][i]) begin
          pend_row.push_back(row_q[r]);
          pend_lane.push_back(i);
        end
      end
    end
    n = 0;
    while (n < max_wb && pend_row.size() > 0) begin
      case (order)
        0: k = $urandom_range(pend_row.size() - 1);
        1: k = pend_row.size() - 1;
        default: k = 0;
      endcase
      writeback[n].en        <= 1'b1;
      writeback[n].bank_addr <= BANK_W'(pend_lane[k]);
      writeback[n].rob_addr  <= ROW_W'(pend_row[k]);
      writeback[n].phys_rd   <= m_payload[pend_row[k]][pend_lane[k]].phys_rd;
      pend_row.delete(k);
      pend_lane.delete(k);
      n++;
    end
  endtask

  // lane 0 looks at the newest producer and the newest result
  task automatic set_lookups();
    op_fetch_phys_rs1[0] <= last_disp_rd;
    op_fetch_phys_rs2[0] <= last_wb_rd;
    for (int i = 1; i < DW; i++) begin
      op_fetch_phys_rs1[i] <= PREG_W'($urandom);
      op_fetch_phys_rs2[i] <= PREG_W'($urandom);
    end
  endtask

  task automatic run_cycle(int lanes, int max_wb, int order);
    @(posedge clk);
    apply_edge();
    clear_inputs();
    drive_group(lanes);
    drive_writebacks(max_wb, order);
    set_lookups();
  endtask

  task automatic drain(int order, int max_wb);
    do begin
      run_cycle(0, max_wb, order);
    end while (row_q.size() != 0);
  endtask

  task automatic fill_and_recover();
    logic [ROW_W-1:0] freed_row;
    for (int g = 0; g < ROB_ROWS; g++) begin
      run_cycle(1 + (g % 2), 0, 0);
    end
    // one group too many
    run_cycle(2, 0, 0);
    @(negedge clk);
    // the oldest row is the one that frees up first
    freed_row = ROW_W'(row_q[0]);
    if (dispatch_full !== 1'b1)
      report_mismatch("dispatch_full", 1'b1, dispatch_full);
    run_cycle(0, 2, 2);
    @(negedge clk);
    if (dispatch_rob_addr[0] !== freed_row)
      report_mismatch("dispatch_rob_addr[0]", freed_row, dispatch_rob_addr[0]);
    while (row_q.size() == ROB_ROWS) begin
      run_cycle(0, 0, 0);
    end
    run_cycle(1, 0, 0);
    @(negedge clk);
    if (dispatch_rob_addr[0] !== freed_row)
      report_mismatch("dispatch_rob_addr[0]", freed_row, dispatch_rob_addr[0]);
  endtask

  task automatic compare_outputs();
    rob_types_pkg::commit_lane_t exp_c;
    for (int i = 0; i < DW; i++) begin
      exp_c = expected_commit(i);
      if (commit[i].en !== exp_c.en)
        report_mismatch($sformatf("commit[%0d].en", i), exp_c.en, commit[i].en);
      if (exp_c.en && commit[i].payload !== exp_c.payload)
        report_mismatch($sformatf("commit[%0d].payload", i), exp_c.payload, commit[i].payload);
      if (dispatch_bank_addr[i] !== BANK_W'(i))
        report_mismatch($sformatf("dispatch_bank_addr[%0d]", i), i, dispatch_bank_addr[i]);
      if (dispatch_rob_addr[i] !== ROW_W'(groups_accepted % ROB_ROWS))
        report_mismatch($sformatf("dispatch_rob_addr[%0d]", i),
                        groups_accepted % ROB_ROWS, dispatch_rob_addr[i]);
      if (op_fetch_rs1_valid[i] !== exp_ready[op_fetch_phys_rs1[i]])
        report_mismatch($sformatf("op_fetch_rs1_valid[%0d]", i),
                        exp_ready[op_fetch_phys_rs1[i]], op_fetch_rs1_valid[i]);
      if (op_fetch_rs2_valid[i] !== exp_ready[op_fetch_phys_rs2[i]])
        report_mismatch($sformatf("op_fetch_rs2_valid[%0d]", i),
                        exp_ready[op_fetch_phys_rs2[i]], op_fetch_rs2_valid[i]);
    end
    if (dispatch_full !== exp_full)
      report_mismatch("dispatch_full", exp_full, dispatch_full);
  endtask

  always @(negedge clk) begin
    if (rst_n)
      compare_outputs();
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing, errors: %0d",
               cycle_count, error_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    void'($urandom(93361));
    last_disp_rd = '0;
    last_wb_rd   = '0;
    for (int p = 0; p < NUM_PREGS; p++) begin
      exp_ready[p] = 1'b1;
    end
    clear_inputs();
    set_lookups();
    wait (rst_n === 1'b1);
    @(negedge clk);
    // state right after reset
    for (int i = 0; i < DW; i++) begin
      if (commit[i].en !== 1'b0)
        report_mismatch($sformatf("commit[%0d].en", i), 1'b0, commit[i].en);
      if (op_fetch_rs1_valid[i] !== 1'b1)
        report_mismatch($sformatf("op_fetch_rs1_valid[%0d]", i), 1'b1, op_fetch_rs1_valid[i]);
      if (op_fetch_rs2_valid[i] !== 1'b1)
        report_mismatch($sformatf("op_fetch_rs2_valid[%0d]", i), 1'b1, op_fetch_rs2_valid[i]);
    end
    if (dispatch_full !== 1'b0)
      report_mismatch("dispatch_full", 1'b0, dispatch_full);
    repeat (RANDOM_CYCLES) begin
      run_cycle($urandom_range(2), $urandom_range(2), 0);
    end
    drain(0, 2);
    // completions youngest first, commits still in program order
    run_cycle(2, 0, 0);
    run_cycle(1, 0, 0);
    run_cycle(2, 0, 0);
    run_cycle(1, 0, 0);
    drain(1, 1);
    fill_and_recover();
    drain(2, 2);
    run_cycle(0, 0, 0);
    @(posedge clk);
    $display("groups: %0d, rows committed: %0d, errors: %0d",
             groups_accepted, rows_committed, error_count);
    if (error_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // release on an edge so the first active edge is the next one
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- logic/rob_top.sv
`timescale 1ns/10ps
`default_nettype none

module rob_top #(
  parameter int DISPATCH_WIDTH = rob_cfg_pkg::DISPATCH_WIDTH,
  parameter int ROB_ROWS       = rob_cfg_pkg::ROB_ROWS,
  parameter int NUM_PREGS      = rob_cfg_pkg::NUM_PREGS,
  localparam int ROW_W         = $clog2(ROB_ROWS),
  localparam int PREG_W        = $clog2(NUM_PREGS)
) (
  input  logic clk,
  input  logic rst_n,

  // dispatch
  input  rob_types_pkg::dispatch_lane_t dispatch [DISPATCH_WIDTH],
  output logic [rob_cfg_pkg::DISPATCH_ADDR_WIDTH-1:0] dispatch_bank_addr [DISPATCH_WIDTH],
  output logic [ROW_W-1:0]              dispatch_rob_addr [DISPATCH_WIDTH],
  output logic                          dispatch_full,

  // writeback
  input  rob_types_pkg::wb_lane_t       writeback [DISPATCH_WIDTH],

  // commit
  output rob_types_pkg::commit_lane_t   commit [DISPATCH_WIDTH],

  // operand fetch
  input  logic [PREG_W-1:0]             op_fetch_phys_rs1 [DISPATCH_WIDTH],
  input  logic [PREG_W-1:0]             op_fetch_phys_rs2 [DISPATCH_WIDTH],
  output logic                          op_fetch_rs1_valid [DISPATCH_WIDTH],
  output logic                          op_fetch_rs2_valid [DISPATCH_WIDTH]
);

  logic                      alloc;
  logic                      retire;
  logic                      full;
  logic [ROW_W-1:0]          tail_row;
  logic [ROW_W-1:0]          head_row;
  logic [DISPATCH_WIDTH-1:0] bank_alloc;
  rob_types_pkg::bank_head_t heads [DISPATCH_WIDTH];

  rob_retire_ctrl #(
    .ROB_ROWS       (ROB_ROWS),
    .DISPATCH_WIDTH (DISPATCH_WIDTH)
  ) retire_ctrl_inst (
    .clk, .rst_n,
    .dispatch_en (dispatch[0].en),
    .heads, .alloc, .tail_row, .head_row, .retire, .full, .commit
  );

  // lane i always lands in bank i at the tail row
  for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_bank
    assign bank_alloc[i]         = alloc && dispatch[i].en;
    assign dispatch_bank_addr[i] = rob_cfg_pkg::DISPATCH_ADDR_WIDTH'(i);
    assign dispatch_rob_addr[i]  = tail_row;

    rob_bank #(
      .ROB_ROWS       (ROB_ROWS),
      .DISPATCH_WIDTH (DISPATCH_WIDTH),
      .LANE           (i)
    ) bank_inst (
      .clk, .rst_n,
      .alloc      (bank_alloc[i]),
      .alloc_row  (tail_row),
      .alloc_data (dispatch[i].payload),
      .wb         (writeback),
      .retire, .head_row,
      .head       (heads[i])
    );

    // groups fill from lane 0 up
    if (i > 0) begin : g_lane_order
      a_lane_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        dispatch[i].en |-> dispatch[0].en
      ) else $error("dispatch lane %0d enabled without lane 0", i);
    end
  end

  preg_ready_table #(
    .NUM_PREGS      (NUM_PREGS),
    .DISPATCH_WIDTH (DISPATCH_WIDTH)
  ) ready_table_inst (
    .clk, .rst_n, .alloc, .dispatch,
    .wb        (writeback),
    .rs1       (op_fetch_phys_rs1),
    .rs2       (op_fetch_phys_rs2),
    .rs1_valid (op_fetch_rs1_valid),
    .rs2_valid (op_fetch_rs2_valid)
  );

  assign dispatch_full = full;

endmodule

`default_nettype wire

//--- logic/preg_ready_table.sv
`timescale 1ns/10ps
`default_nettype none

module preg_ready_table #(
  parameter int NUM_PREGS      = rob_cfg_pkg::NUM_PREGS,
  parameter int DISPATCH_WIDTH = rob_cfg_pkg::DISPATCH_WIDTH,
  localparam int PREG_W        = $clog2(NUM_PREGS)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alloc,
  input  rob_types_pkg::dispatch_lane_t dispatch [DISPATCH_WIDTH],
  input  rob_types_pkg::wb_lane_t       wb [DISPATCH_WIDTH],
  input  logic [PREG_W-1:0]             rs1 [DISPATCH_WIDTH],
  input  logic [PREG_W-1:0]             rs2 [DISPATCH_WIDTH],
  output logic                          rs1_valid [DISPATCH_WIDTH],
  output logic                          rs2_valid [DISPATCH_WIDTH]
);

  logic [NUM_PREGS-1:0] ready_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= '1;
    end else begin
      // new producer in flight
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (alloc && dispatch[i].en) begin
          ready_q[dispatch[i].payload.phys_rd] <= 1'b0;
        end
      end
      // result available
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (wb[i].en) begin
          ready_q[wb[i].phys_rd] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      rs1_valid[i] = ready_q[rs1[i]];
      rs2_valid[i] = ready_q[rs2[i]];
    end
  end

  // a register still owned by an in-flight op can't be handed out again
  for (genvar d = 0; d < DISPATCH_WIDTH; d++) begin : g_disp_chk
    for (genvar w = 0; w < DISPATCH_WIDTH; w++) begin : g_wb_chk
      a_no_clash: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(alloc && dispatch[d].en && wb[w].en
          && dispatch[d].payload.phys_rd == wb[w].phys_rd)
      ) else $error("p%0d dispatched and written back together", wb[w].phys_rd);
    end
  end

endmodule

`default_nettype wire

//--- logic/rob_retire_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module rob_retire_ctrl #(
  parameter int ROB_ROWS       = rob_cfg_pkg::ROB_ROWS,
  parameter int DISPATCH_WIDTH = rob_cfg_pkg::DISPATCH_WIDTH,
  localparam int ROW_W         = $clog2(ROB_ROWS)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        dispatch_en,
  input  rob_types_pkg::bank_head_t   heads [DISPATCH_WIDTH],
  output logic                        alloc,
  output logic [ROW_W-1:0]            tail_row,
  output logic [ROW_W-1:0]            head_row,
  output logic                        retire,
  output logic                        full,
  output rob_types_pkg::commit_lane_t commit [DISPATCH_WIDTH]
);

  localparam int OCC_W = $clog2(ROB_ROWS + 1);

  logic [ROW_W-1:0] head_q;
  logic [ROW_W-1:0] tail_q;
  logic [OCC_W-1:0] occ_q;
  logic [OCC_W-1:0] occ_next;
  logic             full_q;

  // row retires once lane 0 is done and the others are done or empty
  always_comb begin
    retire = heads[0].valid && heads[0].done;
    for (int i = 1; i < DISPATCH_WIDTH; i++) begin
      retire = retire && (!heads[i].valid || heads[i].done);
    end
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      commit[i].en      = retire && heads[i].valid;
      commit[i].payload = heads[i].payload;
    end
  end

  assign alloc    = dispatch_en && !full_q;
  assign occ_next = occ_q + OCC_W'(alloc) - OCC_W'(retire);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      occ_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (retire) begin
        head_q <= (head_q == ROW_W'(ROB_ROWS - 1)) ? '0 : head_q + 1'b1;
      end
      if (alloc) begin
        tail_q <= (tail_q == ROW_W'(ROB_ROWS - 1)) ? '0 : tail_q + 1'b1;
      end
      occ_q  <= occ_next;
      full_q <= (occ_next == OCC_W'(ROB_ROWS));
    end
  end

  assign head_row = head_q;
  assign tail_row = tail_q;
  assign full     = full_q;

  a_occ_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    occ_q <= OCC_W'(ROB_ROWS)
  ) else $error("occupancy %0d above %0d rows", occ_q, ROB_ROWS);

endmodule

`default_nettype wire

//--- logic/rob_bank.sv
`timescale 1ns/10ps
`default_nettype none

module rob_bank #(
  parameter int ROB_ROWS       = rob_cfg_pkg::ROB_ROWS,
  parameter int DISPATCH_WIDTH = rob_cfg_pkg::DISPATCH_WIDTH,
  parameter int LANE           = 0,
  localparam int ROW_W         = $clog2(ROB_ROWS)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        alloc,
  input  logic [ROW_W-1:0]            alloc_row,
  input  rob_types_pkg::rob_payload_t alloc_data,
  input  rob_types_pkg::wb_lane_t     wb [DISPATCH_WIDTH],
  input  logic                        retire,
  input  logic [ROW_W-1:0]            head_row,
  output rob_types_pkg::bank_head_t   head
);

  localparam logic [rob_cfg_pkg::DISPATCH_ADDR_WIDTH-1:0] LANE_ADDR =
    rob_cfg_pkg::DISPATCH_ADDR_WIDTH'(LANE);

  logic [ROB_ROWS-1:0]         valid_q;
  logic [ROB_ROWS-1:0]         done_q;
  rob_types_pkg::rob_payload_t payload_q [ROB_ROWS];

  // per-row status
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (retire) begin
        valid_q[head_row] <= 1'b0;
        done_q[head_row]  <= 1'b0;
      end
      if (alloc) begin
        valid_q[alloc_row] <= 1'b1;
        done_q[alloc_row]  <= 1'b0;
      end
      // completions for this bank only
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (wb[i].en && wb[i].bank_addr == LANE_ADDR) begin
          done_q[wb[i].rob_addr] <= 1'b1;
        end
      end
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (alloc) begin
      payload_q[alloc_row] <= alloc_data;
    end
  end

  always_comb begin
    head.valid   = valid_q[head_row];
    head.done    = done_q[head_row];
    head.payload = payload_q[head_row];
  end

  // a completion must belong to a live, still pending entry
  for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_wb_chk
    a_wb_target: assert property (
      @(posedge clk) disable iff (!rst_n)
      (wb[i].en && wb[i].bank_addr == LANE_ADDR)
        |-> (valid_q[wb[i].rob_addr] && !done_q[wb[i].rob_addr])
    ) else $error("bank %0d: writeback to row %0d not pending", LANE, wb[i].rob_addr);
  end

  // tail must never wrap onto a live row
  a_alloc_free: assert property (
    @(posedge clk) disable iff (!rst_n)
    alloc |-> !valid_q[alloc_row]
  ) else $error("bank %0d: alloc into live row %0d", LANE, alloc_row);

endmodule

`default_nettype wire

//--- logic/rob_types_pkg.sv
package rob_types_pkg;

  // what each entry keeps until commit
  typedef struct packed {
    logic [rob_cfg_pkg::PHYS_REGS_ADDR_WIDTH-1:0] phys_rd;
    logic [rob_cfg_pkg::ARCH_REG_WIDTH-1:0]       arch_rd;
    logic [rob_cfg_pkg::XLEN-1:0]                 pc;
    logic [rob_cfg_pkg::XLEN-1:0]                 instr;
  } rob_payload_t;

  // one dispatch slot
  typedef struct packed {
    logic         en;
    rob_payload_t payload;
  } dispatch_lane_t;

  // completion of one entry, addressed by bank and row
  typedef struct packed {
    logic                                         en;
    logic [rob_cfg_pkg::DISPATCH_ADDR_WIDTH-1:0]  bank_addr;
    logic [rob_cfg_pkg::ROB_ADDR_WIDTH-1:0]       rob_addr;
    logic [rob_cfg_pkg::PHYS_REGS_ADDR_WIDTH-1:0] phys_rd;
  } wb_lane_t;

  // one retiring slot
  typedef struct packed {
    logic         en;
    rob_payload_t payload;
  } commit_lane_t;

  // head row state as seen by the retire logic
  typedef struct packed {
    logic         valid;
    logic         done;
    rob_payload_t payload;
  } bank_head_t;

endpackage

//--- logic/rob_cfg_pkg.sv
package rob_cfg_pkg;

  // lanes dispatched and committed per cycle
  localparam int DISPATCH_WIDTH = 2;

  // rows held by each lane bank
  localparam int ROB_ROWS = 8;
  localparam int ROB_ADDR_WIDTH = 3;

  // selects the bank, one bank per lane
  localparam int DISPATCH_ADDR_WIDTH = 1;

  // physical register space
  localparam int NUM_PREGS = 64;
  localparam int PHYS_REGS_ADDR_WIDTH = 6;

  // architectural register index, x0..x31
  localparam int ARCH_REG_WIDTH = 5;

  // instruction and pc width
  localparam int XLEN = 32;

endpackage
